//--- sim.f
design/soc_bus_pkg.sv
design/soc_periph_pkg.sv
design/baud_counter.sv
design/uart_tx.sv
design/gpio_regs.sv
design/dbus_decoder.sv
design/sram_port_sequencer.sv
design/soc_subsystem.sv
tests/tb_soc_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f \
    --top-module tb_soc_subsystem -o tb_soc_subsystem

./obj_dir/tb_soc_subsystem 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"

//--- tests/tb_soc_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc_subsystem
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
();

    localparam int          NUM_TESTS        = 6;
    localparam int          RAM_OPS          = 16;
    localparam int          CONT_ROUNDS      = 8;
    localparam int          DONE_LIMIT       = 12;
    localparam int          SRAM_WORDS       = 1024;
    localparam logic [31:0] GPIO_OUT_ADDR    = 32'hbfd0_0000;
    localparam logic [31:0] GPIO_IN_ADDR     = 32'hbfd0_0004;
    localparam logic [31:0] UART_DATA_ADDR   = 32'hbfd0_1000;
    localparam logic [31:0] UART_STATUS_ADDR = 32'hbfd0_1004;

    logic       clk;
    logic       rst;
    bus_req_t   ibus_req;
    bus_rsp_t   ibus_rsp;
    bus_req_t   dbus_req;
    bus_rsp_t   dbus_rsp;
    sram_pins_t sram_pins;
    bus_word_t  sram_rdata;
    bus_word_t  gpio_in;
    bus_word_t  gpio_out;
    logic       txd;
    logic       uart_irq;

    integer     seed = 32'hb65c;
    int         cycle_cnt = 0;
    string      test_name = "reset";
    bus_word_t  sram_mem [SRAM_WORDS];
    bus_word_t  ref_ram [SRAM_WORDS];
    bus_word_t  exp_gpio;
    logic [7:0] exp_uart[$];
    logic [7:0] rx_bytes[$];

    soc_subsystem i_soc_subsystem (
        .clk         (clk),
        .rst_i       (rst),
        .ibus_req_i  (ibus_req),
        .ibus_rsp_o  (ibus_rsp),
        .dbus_req_i  (dbus_req),
        .dbus_rsp_o  (dbus_rsp),
        .sram_o      (sram_pins),
        .sram_data_i (sram_rdata),
        .gpio_i      (gpio_in),
        .gpio_o      (gpio_out),
        .txd_o       (txd),
        .uart_irq_o  (uart_irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ============================================================
    // Failure reporting and checks
    // ============================================================

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(input string what, input bus_word_t exp, input bus_word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error in %s, %s: expected %h, actual %h",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error in %s, %s: expected %b, actual %b",
                                    test_name, what, exp, act));
        end
    endtask

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        stop_on_error("Watchdog expired before all tests finished");
    end

    // ============================================================
    // SRAM model and reference model
    // ============================================================

    function automatic bus_word_t fill_word(input int idx);
        return 32'(idx) * 32'h9e37_79b1 ^ 32'h5a5a_0000;
    endfunction

    initial begin
        for (int i = 0; i < SRAM_WORDS; i++) begin
            sram_mem[i] <= fill_word(i);
            ref_ram[i] = fill_word(i);
        end
    end

    assign sram_rdata = sram_mem[sram_pins.addr[9:0]];

    always @(posedge clk) begin
        if (!sram_pins.ce_n && !sram_pins.we_n) begin
            check_bit("data_oe during write", 1'b1, sram_pins.data_oe);
            for (int b = 0; b < 4; b++) begin
                if (!sram_pins.be_n[b]) begin
                    sram_mem[sram_pins.addr[9:0]][8*b +: 8] <= sram_pins.wrdata[8*b +: 8];
                end
            end
        end
    end

    function automatic void model_write(input logic [9:0] w, input bus_word_t data,
                                        input logic [3:0] be);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_ram[w][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    // Bits 27..22 are ignored by the decode, so they get random filler
    function automatic logic [31:0] ram_addr(input logic [9:0] w, input logic [5:0] hi);
        return {RAM_REGION, hi, 10'h000, w, 2'b00};
    endfunction

    // Recovers each UART frame by sampling txd in the middle of every bit
    initial begin : uart_monitor
        logic [7:0] rx;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (txd === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
                check_bit("uart start bit", 1'b0, txd);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    rx[i] = txd;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_bit("uart stop bit", 1'b1, txd);
                rx_bytes.push_back(rx);
            end
        end
    end

    // ============================================================
    // Data bus access, called and left on a falling edge
    // ============================================================

    task automatic dbus_access(input logic wr, input logic [31:0] addr, input bus_word_t wdata,
                               input logic [3:0] be, output bus_word_t rdata, output int lat);
        int n;
        n = 0;
        dbus_req.addr   = addr;
        dbus_req.wrdata = wdata;
        dbus_req.byteen = be;
        dbus_req.read   = ~wr;
        dbus_req.write  = wr;
        do begin
            @(negedge clk);
            n++;
            dbus_req.read  = 1'b0;
            dbus_req.write = 1'b0;
            if (n > DONE_LIMIT) begin
                stop_on_error($sformatf("No done on the data bus within %0d cycles in %s",
                                        DONE_LIMIT, test_name));
            end
        end while (!dbus_rsp.done);
        rdata = dbus_rsp.rddata;
        lat   = n;
    endtask

    task automatic dbus_write(input logic [31:0] addr, input bus_word_t wdata,
                              input logic [3:0] be, input int exp_lat);
        bus_word_t rdata;
        int        lat;
        dbus_access(1'b1, addr, wdata, be, rdata, lat);
        check_word("write latency", exp_lat, lat);
    endtask

    task automatic dbus_read_check(input logic [31:0] addr, input bus_word_t exp_data,
                                   input int exp_lat, input string what);
        bus_word_t rdata;
        int        lat;
        dbus_access(1'b0, addr, '0, 4'hf, rdata, lat);
        check_word(what, exp_data, rdata);
        check_word({what, " latency"}, exp_lat, lat);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin : main_seq
        logic [9:0]  w;
        logic [9:0]  iw;
        logic [9:0]  dw;
        logic [9:0]  words[$];
        bus_word_t   data;
        bus_word_t   exp_i;
        bus_word_t   exp_d;
        logic [3:0]  be;
        logic        dwr;
        logic        i_done;
        logic        d_done;
        int          i_lat;
        int          d_lat;
        int          t_fall;
        logic [7:0]  tx_byte;

        rst      = 1'b1;
        ibus_req = '0;
        dbus_req = '0;
        gpio_in  = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        check_bit("ce_n", 1'b1, sram_pins.ce_n);
        check_bit("oe_n", 1'b1, sram_pins.oe_n);
        check_bit("we_n", 1'b1, sram_pins.we_n);
        check_word("be_n", 32'h0000_000f, {28'h0, sram_pins.be_n});
        check_bit("data_oe", 1'b0, sram_pins.data_oe);
        check_bit("ibus done", 1'b0, ibus_rsp.done);
        check_bit("dbus done", 1'b0, dbus_rsp.done);
        check_bit("txd", 1'b1, txd);
        check_bit("uart irq", 1'b0, uart_irq);
        check_word("gpio_o", 32'h0, gpio_out);

        test_name = "ram";
        for (int i = 0; i < RAM_OPS; i++) begin
            w    = 10'($random(seed));
            data = $random(seed);
            be   = 4'($random(seed));
            dbus_write(ram_addr(w, 6'($random(seed))), data, be, 3);
            model_write(w, data, be);
            words.push_back(w);
        end
        foreach (words[i]) begin
            dbus_read_check(ram_addr(words[i], 6'($random(seed))), ref_ram[words[i]], 3,
                            "read back");
        end

        // Instruction reads use the lower half, data accesses the upper half
        test_name = "contention";
        for (int r = 0; r < CONT_ROUNDS; r++) begin
            iw    = {1'b0, 9'($random(seed))};
            dw    = {1'b1, 9'($random(seed))};
            dwr   = 1'($random(seed));
            data  = $random(seed);
            be    = 4'($random(seed));
            exp_i = ref_ram[iw];
            exp_d = ref_ram[dw];
            ibus_req = '{addr: ram_addr(iw, 6'h00), wrdata: '0, byteen: 4'hf,
                         read: 1'b1, write: 1'b0};
            dbus_req = '{addr: ram_addr(dw, 6'h00), wrdata: data, byteen: be,
                         read: ~dwr, write: dwr};
            i_done = 1'b0;
            d_done = 1'b0;
            i_lat  = 0;
            d_lat  = 0;
            for (int n = 1; n <= 10; n++) begin
                @(negedge clk);
                ibus_req.read  = 1'b0;
                dbus_req.read  = 1'b0;
                dbus_req.write = 1'b0;
                if (ibus_rsp.done) begin
                    if (i_done) begin
                        stop_on_error("A second done pulsed on the instruction bus");
                    end
                    i_done = 1'b1;
                    i_lat  = n;
                    check_word("ibus read", exp_i, ibus_rsp.rddata);
                end
                if (dbus_rsp.done) begin
                    if (d_done) begin
                        stop_on_error("A second done pulsed on the data bus");
                    end
                    d_done = 1'b1;
                    d_lat  = n;
                    if (!dwr) begin
                        check_word("dbus read", exp_d, dbus_rsp.rddata);
                    end
                end
            end
            check_bit("ibus done seen", 1'b1, i_done);
            check_bit("dbus done seen", 1'b1, d_done);
            check_word("first latency", 3, (i_lat < d_lat) ? i_lat : d_lat);
            if (i_lat > 6 || d_lat > 6) begin
                stop_on_error("The waiting port took more than 3 extra cycles");
            end
            if (dwr) begin
                model_write(dw, data, be);
            end
        end

        test_name = "gpio";
        for (int i = 0; i < 4; i++) begin
            exp_gpio = $random(seed);
            dbus_write(GPIO_OUT_ADDR, exp_gpio, 4'hf, 1);
            check_word("gpio_o", exp_gpio, gpio_out);
            dbus_read_check(GPIO_OUT_ADDR, exp_gpio, 1, "out readback");
            gpio_in = $random(seed);
            @(negedge clk);
            dbus_read_check(GPIO_IN_ADDR, gpio_in, 1, "in readback");
        end

        test_name = "uart";
        dbus_read_check(UART_STATUS_ADDR, 32'h0, 1, "status idle");
        for (int f = 0; f < 2; f++) begin
            tx_byte = 8'($random(seed));
            check_bit("txd idle", 1'b1, txd);
            dbus_write(UART_DATA_ADDR, {24'h0, tx_byte}, 4'hf, 1);
            exp_uart.push_back(tx_byte);
            t_fall = cycle_cnt;
            check_bit("txd start", 1'b0, txd);
            // This one lands while busy and must not become a frame
            dbus_write(UART_DATA_ADDR, {24'h0, ~tx_byte}, 4'hf, 1);
            dbus_read_check(UART_STATUS_ADDR, 32'h1, 1, "status busy");
            while (!uart_irq) begin
                @(negedge clk);
            end
            check_word("frame length", 80, cycle_cnt - t_fall);
            dbus_read_check(UART_STATUS_ADDR, 32'h2, 1, "status irq");
            check_bit("irq cleared", 1'b0, uart_irq);
            dbus_read_check(UART_STATUS_ADDR, 32'h0, 1, "status cleared");
        end
        check_word("frames received", exp_uart.size(), rx_bytes.size());
        foreach (exp_uart[i]) begin
            check_word("received byte", {24'h0, exp_uart[i]}, {24'h0, rx_bytes[i]});
        end

        test_name = "unmapped";
        dbus_read_check(32'h1000_0040, 32'h0, 1, "low region read");
        dbus_read_check(32'hbfd0_2000, 32'h0, 1, "empty block read");
        dbus_write(32'h0000_0040, $random(seed), 4'hf, 1);
        dbus_write(32'hbfd0_3000, $random(seed), 4'hf, 1);
        dbus_read_check(ram_addr(10'd16, 6'h00), ref_ram[16], 3, "ram unchanged");
        dbus_read_check(GPIO_OUT_ADDR, exp_gpio, 1, "gpio unchanged");
        check_word("gpio_o unchanged", exp_gpio, gpio_out);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/soc_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module soc_subsystem
    import soc_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  bus_req_t   ibus_req_i,
    output bus_rsp_t   ibus_rsp_o,
    input  bus_req_t   dbus_req_i,
    output bus_rsp_t   dbus_rsp_o,
    output sram_pins_t sram_o,
    input  bus_word_t  sram_data_i,
    input  bus_word_t  gpio_i,
    output bus_word_t  gpio_o,
    output logic       txd_o,
    output logic       uart_irq_o
);

    bus_req_t   ram_req;
    bus_rsp_t   ram_rsp;
    logic       gpio_wr;
    logic       uart_rd;
    logic       uart_wr;
    logic [1:0] reg_idx;
    bus_word_t  wrdata;
    bus_word_t  gpio_rddata;
    bus_word_t  uart_rddata;

    // ============================================================
    // Data bus decode and shared SRAM
    // ============================================================

    dbus_decoder i_dbus_decoder (
        .clk           (clk),
        .rst_i         (rst_i),
        .req_i         (dbus_req_i),
        .rsp_o         (dbus_rsp_o),
        .ram_req_o     (ram_req),
        .ram_rsp_i     (ram_rsp),
        .gpio_rd_o     (),
        .gpio_wr_o     (gpio_wr),
        .uart_rd_o     (uart_rd),
        .uart_wr_o     (uart_wr),
        .reg_idx_o     (reg_idx),
        .wrdata_o      (wrdata),
        .gpio_rddata_i (gpio_rddata),
        .uart_rddata_i (uart_rddata)
    );

    sram_port_sequencer i_sram_port_sequencer (
        .clk         (clk),
        .rst_i       (rst_i),
        .iport_req_i (ibus_req_i),
        .dport_req_i (ram_req),
        .iport_rsp_o (ibus_rsp_o),
        .dport_rsp_o (ram_rsp),
        .sram_o      (sram_o),
        .sram_data_i (sram_data_i)
    );

    // ============================================================
    // Peripherals
    // ============================================================

    gpio_regs i_gpio_regs (
        .clk       (clk),
        .rst_i     (rst_i),
        .wr_i      (gpio_wr),
        .reg_idx_i (reg_idx),
        .wrdata_i  (wrdata),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .rddata_o  (gpio_rddata)
    );

    uart_tx i_uart_tx (
        .clk       (clk),
        .rst_i     (rst_i),
        .rd_i      (uart_rd),
        .wr_i      (uart_wr),
        .reg_idx_i (reg_idx),
        .wrdata_i  (wrdata),
        .rddata_o  (uart_rddata),
        .txd_o     (txd_o),
        .irq_o     (uart_irq_o)
    );

endmodule

`default_nettype wire

//--- design/sram_port_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sram_port_sequencer
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  bus_req_t   iport_req_i,
    input  bus_req_t   dport_req_i,
    output bus_rsp_t   iport_rsp_o,
    output bus_rsp_t   dport_rsp_o,
    output sram_pins_t sram_o,
    input  bus_word_t  sram_data_i
);

    typedef enum logic [1:0] {
        ST_GRANT,
        ST_DRIVE,
        ST_DONE
    } seq_state_t;

    seq_state_t   state_q;
    logic [1:0]   pend_q;
    logic [1:0]   pend_d;
    logic         i_new;
    logic         d_new;
    logic         cur_q;
    logic         pick_d;
    bus_req_t     ireq_q;
    bus_req_t     dreq_q;
    bus_req_t     acc_q;
    bus_word_t    rdata_q;
    periph_addr_u acc_addr;

    assign i_new = iport_req_i.read | iport_req_i.write;
    assign d_new = dport_req_i.read | dport_req_i.write;

    // Bit 0 is ibus and bit 1 is dbus. cur_q is high while dbus is in service
    // and keeps the last served port once the access is over
    assign pick_d = pend_q[1] & (~pend_q[0] | ~cur_q);

    always_comb begin
        pend_d = pend_q;
        if (state_q == ST_GRANT && |pend_q) begin
            pend_d[pick_d] = 1'b0;
        end
        if (i_new) begin
            pend_d[0] = 1'b1;
        end
        if (d_new) begin
            pend_d[1] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_GRANT;
            pend_q  <= '0;
            cur_q   <= 1'b1;
        end else begin
            pend_q <= pend_d;
            case (state_q)
                ST_GRANT: begin
                    if (|pend_q) begin
                        state_q <= ST_DRIVE;
                        cur_q   <= pick_d;
                    end
                end
                ST_DRIVE: state_q <= ST_DONE;
                default:  state_q <= ST_GRANT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_new) begin
            ireq_q <= iport_req_i;
        end
        if (d_new) begin
            dreq_q <= dport_req_i;
        end
        if (state_q == ST_GRANT) begin
            acc_q <= pick_d ? dreq_q : ireq_q;
        end
        // SRAM output has settled by the end of DRIVE
        if (state_q == ST_DRIVE) begin
            rdata_q <= sram_data_i;
        end
    end

    // ============================================================
    // SRAM pins, active only in DRIVE
    // ============================================================

    assign acc_addr = acc_q.addr;

    always_comb begin
        sram_o.addr    = acc_addr.ram.word;
        sram_o.wrdata  = acc_q.wrdata;
        sram_o.data_oe = 1'b0;
        sram_o.ce_n    = 1'b1;
        sram_o.oe_n    = 1'b1;
        sram_o.we_n    = 1'b1;
        sram_o.be_n    = 4'hf;
        if (state_q == ST_DRIVE) begin
            sram_o.ce_n = 1'b0;
            sram_o.be_n = ~acc_q.byteen;
            if (acc_q.write) begin
                sram_o.we_n    = 1'b0;
                sram_o.data_oe = 1'b1;
            end else begin
                sram_o.oe_n = 1'b0;
            end
        end
    end

    always_comb begin
        iport_rsp_o.rddata = rdata_q;
        iport_rsp_o.done   = (state_q == ST_DONE) && !cur_q;
        dport_rsp_o.rddata = rdata_q;
        dport_rsp_o.done   = (state_q == ST_DONE) && cur_q;
    end

    a_oe_we_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(!sram_o.oe_n && !sram_o.we_n));

    a_done_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(iport_rsp_o.done && dport_rsp_o.done));

endmodule

`default_nettype wire

//--- design/dbus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module dbus_decoder
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  bus_req_t   req_i,
    output bus_rsp_t   rsp_o,
    output bus_req_t   ram_req_o,
    input  bus_rsp_t   ram_rsp_i,
    output logic       gpio_rd_o,
    output logic       gpio_wr_o,
    output logic       uart_rd_o,
    output logic       uart_wr_o,
    output logic [1:0] reg_idx_o,
    output bus_word_t  wrdata_o,
    input  bus_word_t  gpio_rddata_i,
    input  bus_word_t  uart_rddata_i
);

    periph_addr_u addr;
    logic         hit_ram;
    logic         hit_periph;
    logic         hit_gpio;
    logic         hit_uart;
    logic         local_req;
    logic         local_done_q;
    bus_word_t    local_data_d;
    bus_word_t    local_data_q;

    assign addr       = req_i.addr;
    assign hit_ram    = (addr.ram.region == RAM_REGION);
    assign hit_periph = (addr.periph.base == PERIPH_BASE);
    assign hit_gpio   = hit_periph && (addr.periph.block == GPIO_BLOCK);
    assign hit_uart   = hit_periph && (addr.periph.block == UART_BLOCK);

    // RAM requests go straight through to the sequencer data port
    always_comb begin
        ram_req_o       = req_i;
        ram_req_o.read  = req_i.read & hit_ram;
        ram_req_o.write = req_i.write & hit_ram;
    end

    assign gpio_rd_o = req_i.read & hit_gpio;
    assign gpio_wr_o = req_i.write & hit_gpio;
    assign uart_rd_o = req_i.read & hit_uart;
    assign uart_wr_o = req_i.write & hit_uart;
    assign reg_idx_o = addr.periph.reg_idx;
    assign wrdata_o  = req_i.wrdata;

    // Everything that is not RAM, unmapped included, answers one cycle later
    assign local_req = (req_i.read | req_i.write) & ~hit_ram;

    always_comb begin
        if (gpio_rd_o) begin
            local_data_d = gpio_rddata_i;
        end else if (uart_rd_o) begin
            local_data_d = uart_rddata_i;
        end else begin
            local_data_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            local_done_q <= 1'b0;
        end else begin
            local_done_q <= local_req;
        end
    end

    always_ff @(posedge clk) begin
        local_data_q <= local_data_d;
    end

    always_comb begin
        rsp_o.rddata = local_done_q ? local_data_q : ram_rsp_i.rddata;
        rsp_o.done   = local_done_q | ram_rsp_i.done;
    end

    a_one_target: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0({ram_req_o.read, ram_req_o.write, gpio_rd_o, gpio_wr_o,
                  uart_rd_o, uart_wr_o}));

endmodule

`default_nettype wire

//--- design/gpio_regs.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_regs
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       wr_i,
    input  logic [1:0] reg_idx_i,
    input  bus_word_t  wrdata_i,
    input  bus_word_t  gpio_i,
    output bus_word_t  gpio_o,
    output bus_word_t  rddata_o
);

    bus_word_t out_q;
    bus_word_t in_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q <= '0;
        end else if (wr_i && reg_idx_i == GPIO_OUT_REG) begin
            out_q <= wrdata_i;
        end
    end

    // Input pins are sampled every cycle, so a read sees them one clock late
    always_ff @(posedge clk) begin
        in_q <= gpio_i;
    end

    assign gpio_o = out_q;

    always_comb begin
        case (reg_idx_i)
            GPIO_OUT_REG: rddata_o = out_q;
            GPIO_IN_REG:  rddata_o = in_q;
            default:      rddata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       rd_i,
    input  logic       wr_i,
    input  logic [1:0] reg_idx_i,
    input  bus_word_t  wrdata_i,
    output bus_word_t  rddata_o,
    output logic       txd_o,
    output logic       irq_o
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t  state_q;
    logic [7:0] shift_q;
    logic [2:0] bit_idx_q;
    logic       irq_q;
    logic       busy;
    logic       bit_tick;
    logic       data_wr;
    logic       status_rd;

    assign busy      = (state_q != TX_IDLE);
    assign data_wr   = wr_i && (reg_idx_i == UART_DATA_REG);
    assign status_rd = rd_i && (reg_idx_i == UART_STATUS_REG);

    baud_counter i_baud_counter (
        .clk        (clk),
        .rst_i      (rst_i),
        .run_i      (busy),
        .bit_tick_o (bit_tick)
    );

    // ============================================================
    // Frame FSM
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= TX_IDLE;
            bit_idx_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (data_wr) begin
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_tick) begin
                        state_q   <= TX_DATA;
                        bit_idx_q <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_tick) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= TX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_tick) begin
                        state_q <= TX_IDLE;
                    end
                end
            endcase
            // A frame ending in the same cycle as a STATUS read keeps its irq
            if (status_rd) begin
                irq_q <= 1'b0;
            end
            if (state_q == TX_STOP && bit_tick) begin
                irq_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE && data_wr) begin
            shift_q <= wrdata_i[7:0];
        end else if (state_q == TX_DATA && bit_tick) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_comb begin
        case (state_q)
            TX_START: txd_o = 1'b0;
            TX_DATA:  txd_o = shift_q[0];
            default:  txd_o = 1'b1;
        endcase
    end

    always_comb begin
        rddata_o = '0;
        if (reg_idx_i == UART_STATUS_REG) begin
            rddata_o[1:0] = {irq_q, busy};
        end
    end

    assign irq_o = irq_q;

endmodule

`default_nettype wire

//--- design/baud_counter.sv
`timescale 1ns/10ps
`default_nettype none

module baud_counter
    import soc_periph_pkg::*;
(
    input  logic clk,
    input  logic rst_i,
    input  logic run_i,
    output logic bit_tick_o
);

    logic [BAUD_W-1:0] cnt_q;
    logic              last;

    assign last = (int'(cnt_q) == CLKS_PER_BIT - 1);

    always_ff @(posedge clk) begin
        if (rst_i || !run_i || last) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Tick in the last cycle of every bit
    assign bit_tick_o = run_i & last;

    a_cnt_range: assert property (@(posedge clk) disable iff (rst_i)
        int'(cnt_q) < CLKS_PER_BIT);

endmodule

`default_nettype wire

//--- design/soc_periph_pkg.sv
`default_nettype none

package soc_periph_pkg;

    // ============================================================
    // Address views
    // ============================================================

    // RAM view: bits 31..28 pick the region, bits 21..2 index a 32-bit word
    typedef struct packed {
        logic [3:0]  region;
        logic [5:0]  unused;
        logic [19:0] word;
        logic [1:0]  byte_off;
    } ram_view_t;

    // Peripheral view: base, block select and register index
    typedef struct packed {
        logic [15:0] base;
        logic [3:0]  block;
        logic [7:0]  unused;
        logic [1:0]  reg_idx;
        logic [1:0]  byte_off;
    } periph_view_t;

    typedef union packed {
        ram_view_t    ram;
        periph_view_t periph;
    } periph_addr_u;

    localparam logic [3:0] GPIO_BLOCK = 4'd0;
    localparam logic [3:0] UART_BLOCK = 4'd1;

    // Register indexes
    localparam logic [1:0] GPIO_OUT_REG    = 2'd0;
    localparam logic [1:0] GPIO_IN_REG     = 2'd1;
    localparam logic [1:0] UART_DATA_REG   = 2'd0;
    localparam logic [1:0] UART_STATUS_REG = 2'd1;

    // Clocks per UART bit and the width of the bit timer
    localparam int CLKS_PER_BIT = 8;
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT);

endpackage

`default_nettype wire

//--- design/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // ============================================================
    // Processor side bus types
    // ============================================================

    typedef logic [31:0] bus_word_t;

    // One request on a port, valid only in the cycle that read or write is high
    typedef struct packed {
        logic [31:0] addr;
        bus_word_t   wrdata;
        logic [3:0]  byteen;
        logic        read;
        logic        write;
    } bus_req_t;

    // Read data is valid in the cycle that done pulses
    typedef struct packed {
        bus_word_t rddata;
        logic      done;
    } bus_rsp_t;

    // ============================================================
    // External asynchronous SRAM
    // ============================================================

    typedef struct packed {
        logic [19:0] addr;
        bus_word_t   wrdata;
        logic        data_oe;
        logic        ce_n;
        logic        oe_n;
        logic        we_n;
        logic [3:0]  be_n;
    } sram_pins_t;

    // Address map
    localparam logic [3:0]  RAM_REGION  = 4'h8;
    localparam logic [15:0] PERIPH_BASE = 16'hbfd0;

endpackage

`default_nettype wire
